/* common/sqrt_defs.svh */
`ifndef SQRT_DEFS_SVH
`define SQRT_DEFS_SVH

// number of identical lanes, 2, 4 or 8 all work
`define SQRT_LANES 4

// lane iterations, one root bit each
// root width follows from this, radicand is twice as wide
`define SQRT_ITERS 16

// request tag width
`define SQRT_TAG_W 8

`endif

/* common/sqrt_pkg.sv */
`include "sqrt_defs.svh"

package sqrt_pkg;

	// widths that carry a meaning
	typedef logic [`SQRT_ITERS-1:0]          half_t;     // one radicand half
	typedef logic [2*`SQRT_ITERS-1:0]        radicand_t; // full radicand
	typedef logic [`SQRT_ITERS-1:0]          root_t;     // integer root
	typedef logic [`SQRT_ITERS:0]            rem_t;      // corrected remainder, up to 2*root
	typedef logic signed [`SQRT_ITERS+1:0]   raw_rem_t;  // lane working remainder
	typedef logic [`SQRT_TAG_W-1:0]          tag_t;
	typedef logic [$clog2(`SQRT_LANES)-1:0]  lane_idx_t; // round-robin pointer

	// request from the caller
	typedef struct packed
	{
		half_t hi;   // upper half, always used
		half_t lo;   // lower half
		logic  size; // 1 = 32-bit radicand, 0 = hi only
		tag_t  tag;  // returned with the result
	} sqrt_req_t;

	// lane to collector, remainder not yet corrected
	typedef struct packed
	{
		root_t    root;
		raw_rem_t rem;
		tag_t     tag;
	} lane_res_t;

	// final result at the top level
	typedef struct packed
	{
		root_t root;
		rem_t  rem;  // radicand - root*root
		tag_t  tag;
	} sqrt_res_t;

	// lane FSM
	typedef enum logic
	{
		st_idle,
		st_iterate
	} lane_state_t;

endpackage

/* hw/sqrt_dispatch.sv */
`include "sqrt_defs.svh"

module sqrt_dispatch
	import sqrt_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   in_valid,   // request strobe
	input  sqrt_req_t              in_req,
	input  logic [`SQRT_LANES-1:0] lane_ready, // high while lane idle
	output logic [`SQRT_LANES-1:0] lane_load,  // one-hot load strobe
	output sqrt_req_t              lane_req,   // shared by all lanes
	output logic                   busy
);

	lane_idx_t              ptr;        // next lane to serve
	lane_idx_t              ptr_next;
	logic [`SQRT_LANES-1:0] ptr_onehot;
	logic                   load_pend;  // load to pointed lane not yet taken
	logic                   accept;

	// decode pointer
	always_comb
	begin
		for (int i = 0; i < `SQRT_LANES; i++)
			ptr_onehot[i] = (ptr == lane_idx_t'(i));
	end

	// wrap at last lane, also covers non power of two counts
	always_comb
	begin
		if (ptr == lane_idx_t'(`SQRT_LANES - 1))
			ptr_next = '0;
		else
			ptr_next = ptr + 1'b1;
	end

	assign load_pend = |(lane_load & ptr_onehot);

	// pointed lane still busy or about to be
	assign busy = ~lane_ready[ptr] | load_pend;

	// a strobe during busy is dropped
	assign accept = in_valid & ~busy;

	// pointer and load strobe
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ptr       <= '0;
			lane_load <= '0;
		end
		else
		begin
			lane_load <= accept ? ptr_onehot : '0; // one cycle strobe
			if (accept)
				ptr <= ptr_next;                   // round robin
		end
	end

	// request payload, held until the next accept
	always_ff @(posedge clk)
	begin
		if (accept)
			lane_req <= in_req;
	end

	// caller must honour busy
	a_no_strobe_when_busy: assert property (
		@(posedge clk) disable iff (rst)
		in_valid |-> !busy
	) else $error("in_valid raised while busy");

endmodule

/* sqrt_lane/sqrt_lane.sv */
`include "sqrt_defs.svh"

module sqrt_lane
	import sqrt_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      load,  // start strobe from dispatcher
	input  sqrt_req_t req,
	output logic      ready, // idle, may be loaded
	output logic      done,  // one cycle, res valid
	output lane_res_t res
);

	localparam int W     = `SQRT_ITERS;
	localparam int CNT_W = $clog2(`SQRT_ITERS);

	lane_state_t      state;
	logic [CNT_W-1:0] cnt;      // iterations left minus one
	radicand_t        rad;      // shifts left two bits per step
	root_t            root;     // gains one bit per step
	raw_rem_t         rem;      // signed partial remainder
	tag_t             tag;

	logic             sub;      // remainder non-negative, subtract
	raw_rem_t         shifted;  // 4*rem + next radicand pair
	raw_rem_t         trial;    // 4q+1, or 4q+3 with sign bit set
	raw_rem_t         rem_next;

	// add/subtract step
	always_comb
	begin
		sub      = ~rem[W+1];
		shifted  = {rem[W-1:0], rad[2*W-1 -: 2]};  // top bits of rem fall off
		trial    = {root, rem[W+1], 1'b1};
		if (sub)
			rem_next = shifted - trial;
		else
			rem_next = shifted + trial;
	end

	// control FSM
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= st_idle;
			cnt   <= '0;
			done  <= 1'b0;
		end
		else
		begin
			done <= 1'b0;                                // strobe by default
			case (state)
				st_idle:
				begin
					if (load)
					begin
						state <= st_iterate;
						cnt   <= CNT_W'(`SQRT_ITERS - 1); // 16 steps
					end
				end
				st_iterate:
				begin
					if (cnt == '0)
					begin
						state <= st_idle;                 // ready again with done
						done  <= 1'b1;
					end
					else
						cnt <= cnt - 1'b1;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// datapath
	always_ff @(posedge clk)
	begin
		if (load && state == st_idle)
		begin
			rad  <= {req.hi, (req.size ? req.lo : half_t'(0))}; // lo ignored in 16-bit mode
			root <= '0;
			rem  <= '0;
			tag  <= req.tag;
		end
		else if (state == st_iterate)
		begin
			rad  <= rad << 2;
			root <= {root[W-2:0], ~rem_next[W+1]};  // inverted carry is the new bit
			rem  <= rem_next;
		end
	end

	assign ready    = (state == st_idle);
	assign res.root = root;
	assign res.rem  = rem;  // may be negative, collector corrects
	assign res.tag  = tag;

	// dispatcher must not load a running lane
	a_no_load_while_busy: assert property (
		@(posedge clk) disable iff (rst)
		load |-> state == st_idle
	) else $error("load while lane iterating");

	a_done_one_cycle: assert property (
		@(posedge clk) disable iff (rst)
		done |=> !done
	) else $error("done held longer than one cycle");

	// fixed latency keeps results in request order
	a_fixed_latency: assert property (
		@(posedge clk) disable iff (rst)
		load |-> ##(`SQRT_ITERS + 1) done
	) else $error("lane latency off");

endmodule

/* hw/sqrt_collect.sv */
`include "sqrt_defs.svh"

module sqrt_collect
	import sqrt_pkg::*;
(
	input  logic                              clk,
	input  logic                              rst,
	input  logic      [`SQRT_LANES-1:0]       lane_done,
	input  lane_res_t [`SQRT_LANES-1:0]       lane_res,
	output logic                              out_valid,
	output sqrt_res_t                         out_res
);

	localparam int W = `SQRT_ITERS;

	lane_res_t sel;       // result of finishing lane
	logic      any_done;
	rem_t      fixed_rem;

	// lane select, only one done at a time
	always_comb
	begin
		sel = '0;
		for (int i = 0; i < `SQRT_LANES; i++)
		begin
			if (lane_done[i])
				sel = lane_res[i];
		end
	end

	assign any_done = |lane_done;

	// negative remainder means last root bit was 0
	// add back 2q+1 to get radicand - q*q
	always_comb
	begin
		if (sel.rem[W+1])
			fixed_rem = rem_t'(sel.rem) + {sel.root, 1'b1};  // wraps to positive
		else
			fixed_rem = rem_t'(sel.rem);
	end

	// output strobe
	always_ff @(posedge clk)
	begin
		if (rst)
			out_valid <= 1'b0;
		else
			out_valid <= any_done;
	end

	// payload, held between strobes
	always_ff @(posedge clk)
	begin
		if (any_done)
		begin
			out_res.root <= sel.root;
			out_res.rem  <= fixed_rem;
			out_res.tag  <= sel.tag;
		end
	end

	// round robin with equal latency means no two lanes finish together
	a_one_done: assert property (
		@(posedge clk) disable iff (rst)
		$onehot0(lane_done)
	) else $error("more than one lane done in a cycle");

	// corrected remainder never exceeds 2*root
	a_rem_range: assert property (
		@(posedge clk) disable iff (rst)
		out_valid |-> out_res.rem <= {out_res.root, 1'b0}
	) else $error("remainder out of range");

endmodule

/* hw/sqrt_array.sv */
`include "sqrt_defs.svh"

module sqrt_array
	import sqrt_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      in_valid,  // strobe, only while busy low
	input  sqrt_req_t in_req,
	output logic      busy,
	output logic      out_valid, // strobe, 18 edges after request
	output sqrt_res_t out_res
);

	logic      [`SQRT_LANES-1:0] lane_load;
	logic      [`SQRT_LANES-1:0] lane_ready;
	logic      [`SQRT_LANES-1:0] lane_done;
	sqrt_req_t                   lane_req;   // one bus to all lanes
	lane_res_t [`SQRT_LANES-1:0] lane_res;

	// round robin router
	sqrt_dispatch sqrt_dispatch_inst
	(
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.in_req     (in_req),
		.lane_ready (lane_ready),
		.lane_load  (lane_load),
		.lane_req   (lane_req),
		.busy       (busy)
	);

	// identical iterative lanes
	for (genvar i = 0; i < `SQRT_LANES; i++)
	begin : g_lane
		sqrt_lane sqrt_lane_inst
		(
			.clk   (clk),
			.rst   (rst),
			.load  (lane_load[i]),
			.req   (lane_req),
			.ready (lane_ready[i]),
			.done  (lane_done[i]),
			.res   (lane_res[i])
		);
	end

	// result mux, remainder fix, output register
	sqrt_collect sqrt_collect_inst
	(
		.clk       (clk),
		.rst       (rst),
		.lane_done (lane_done),
		.lane_res  (lane_res),
		.out_valid (out_valid),
		.out_res   (out_res)
	);

endmodule

/* verif/sqrt_array_tb.sv */
`include "sqrt_defs.svh"

module sqrt_array_tb
	import sqrt_pkg::*;
();

	localparam int LANES     = `SQRT_LANES;
	localparam int LATENCY   = 18;         // sampling edge to out_valid rise
	localparam int DRV_DLY   = 1;          // input drive after rising edge
	localparam int N_CORNER  = 12;
	localparam int N_HALF    = 20;
	localparam int N_BURST   = 16;
	localparam int N_RAND    = 300;
	localparam int N_TOTAL   = N_CORNER + N_HALF + N_BURST + 1 + N_RAND;
	// ten cycles per request covers gaps and busy stalls, plus reset and drains
	localparam int MAX_CYCLES = N_TOTAL * 10 + 500;

	logic      clk;
	logic      rst;
	logic      in_valid;
	sqrt_req_t in_req;
	logic      busy;
	logic      out_valid;
	sqrt_res_t out_res;

	sqrt_res_t exp_q [$];    // expected results, request order
	int        edge_q [$];   // edge that sampled each request
	sqrt_res_t exp_res;
	int        issue_edge;
	int        cycle = 0;
	int        n_checked = 0;
	int        burst_cnt;
	tag_t      next_tag;
	radicand_t corners [$];

	sqrt_array sqrt_array_inst
	(
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_req    (in_req),
		.busy      (busy),
		.out_valid (out_valid),
		.out_res   (out_res)
	);

	always #4 clk = ~clk;  // period 8

	// integer root by bit-wise trial, remainder is radicand minus root squared
	function automatic sqrt_res_t floor_sqrt(input sqrt_req_t req);
		logic [63:0] x;
		logic [63:0] q;
		logic [63:0] t;
		sqrt_res_t   r;
		int          b;
		x = req.size ? {32'h0, req.hi, req.lo} : {32'h0, req.hi, 16'h0};  // lo dropped
		q = 64'h0;
		for (b = `SQRT_ITERS - 1; b >= 0; b--)
		begin
			t = q | (64'h1 << b);
			if (t * t <= x)
				q = t;  // keep the bit
		end
		r.root = root_t'(q);
		r.rem  = rem_t'(x - q * q);
		r.tag  = req.tag;
		return r;
	endfunction

	task automatic compare_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected)
		begin
			$display("ERROR at time %0t: %s expected %0h, got %0h", $time, name,
				expected, actual);
			$display("** FAIL **");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#DRV_DLY;
		end
	endtask

	// waits for busy low, then strobes one request
	task automatic send_req(input half_t hi, input half_t lo, input logic size);
		while (busy)
		begin
			@(posedge clk);
			#DRV_DLY;
		end
		in_req.hi   = hi;
		in_req.lo   = lo;
		in_req.size = size;
		in_req.tag  = next_tag;
		in_valid    = 1'b1;
		next_tag    = next_tag + 1'b1;  // tags show the order
		@(posedge clk);
		#DRV_DLY;
		in_valid = 1'b0;
	endtask

	// until every expected result came out
	task automatic drain();
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (2) @(posedge clk);
		#DRV_DLY;
	endtask

	// scoreboard, outputs read at the edge before the DUT updates them
	always @(posedge clk)
	begin
		if (!rst)
		begin
			if (out_valid)
			begin
				if (exp_q.size() == 0)
				begin
					$display("result at time %0t with no request outstanding", $time);
					$display("** FAIL **");
					$fatal(1, "unexpected out_valid");
				end
				else
				begin
					exp_res    = exp_q.pop_front();
					issue_edge = edge_q.pop_front();
					compare_value("out_res.tag", exp_res.tag, out_res.tag);
					compare_value("out_res.root", exp_res.root, out_res.root);
					compare_value("out_res.rem", exp_res.rem, out_res.rem);
					// seen one edge after it rises
					compare_value("out_valid latency", LATENCY + 1, cycle - issue_edge);
					n_checked++;
				end
			end
			if (in_valid)  // request issued
			begin
				exp_q.push_back(floor_sqrt(in_req));
				edge_q.push_back(cycle);
			end
		end
	end

	// run limit
	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (cycle >= MAX_CYCLES)
		begin
			$display("timeout after %0d cycles, %0d results missing", cycle, exp_q.size());
			$display("** FAIL **");
			$fatal(1, "run did not complete");
		end
	end

	initial
	begin
		clk      = 1'b0;
		rst      = 1'b1;
		in_valid = 1'b0;
		in_req   = '0;
		next_tag = '0;
		void'($urandom(32'ha6d7_b706));
		repeat (16) @(posedge clk);
		#DRV_DLY;
		rst = 1'b0;

		// quiet outputs after reset
		repeat (6)
		begin
			@(posedge clk);
			compare_value("out_valid", 0, out_valid);
			compare_value("busy", 0, busy);
		end
		#DRV_DLY;

		// corner radicands, 32-bit mode
		corners = '{32'h0000_0000, 32'h0000_0001, 32'h0000_0002, 32'h0000_0003,
			32'h0000_0004, 32'h0000_0009, 32'h0000_0090, 32'h0001_0000,
			32'h4000_0000, 32'hFFFE_0000, 32'hFFFE_0001, 32'hFFFF_FFFF};
		foreach (corners[i])
			send_req(corners[i][31:16], corners[i][15:0], 1'b1);
		drain();

		// 16-bit mode, lo is noise
		repeat (N_HALF)
			send_req(half_t'($urandom), half_t'($urandom), 1'b0);
		drain();

		// back to back from all lanes idle
		burst_cnt = 0;
		while (!busy && burst_cnt < 2 * LANES)
		begin
			send_req(half_t'($urandom), half_t'($urandom), 1'b1);
			burst_cnt++;
		end
		compare_value("requests before busy", LANES, burst_cnt);
		repeat (N_BURST - LANES)
			send_req(half_t'($urandom), half_t'($urandom), 1'b1);
		drain();

		// isolated request, strobe width
		send_req(16'h1234, 16'h5678, 1'b1);
		while (!out_valid)
			@(posedge clk);
		@(posedge clk);
		compare_value("out_valid width", 0, out_valid);
		#DRV_DLY;
		drain();

		// random sizes and gaps
		repeat (N_RAND)
		begin
			idle_cycles($urandom_range(0, 3));
			send_req(half_t'($urandom), half_t'($urandom), logic'($urandom_range(0, 1)));
		end
		drain();

		if (exp_q.size() == 0)
		begin
			$display("%0d results checked", n_checked);
			$display("** PASS **");
			$finish;
		end
		else
		begin
			$display("%0d results never came out", exp_q.size());
			$display("** FAIL **");
			$fatal(1, "results missing");
		end
	end

endmodule

/* sqrt_array.f */
+incdir+common
common/sqrt_pkg.sv
hw/sqrt_dispatch.sv
sqrt_lane/sqrt_lane.sv
hw/sqrt_collect.sv
hw/sqrt_array.sv
verif/sqrt_array_tb.sv
